// ==== build.f ====
rtl/fft_pkg.sv
rtl/bfly_if.sv
rtl/lim_qnt.sv
rtl/butterfly_rad2.sv
rtl/frame_loader.sv
rtl/result_drain.sv
rtl/fft_stage_top.sv
tb/fft_stage_monitor.sv
tb/fft_stage_chk.sv
tb/tb_fft_stage.sv

// ==== rtl/bfly_if.sv ====
`timescale 1ns/10ps

interface bfly_in_if;
    logic                                valid; // one-cycle strobe per frame.
    logic signed [fft_pkg::d_width-1:0]  a_re;
    logic signed [fft_pkg::d_width-1:0]  a_im;
    logic signed [fft_pkg::d_width-1:0]  b_re;
    logic signed [fft_pkg::d_width-1:0]  b_im;
    logic signed [fft_pkg::w_width-1:0]  w_re;
    logic signed [fft_pkg::w_width-1:0]  w_im;
    logic        [fft_pkg::cut_width-1:0] cut;

    modport loader (output valid, a_re, a_im, b_re, b_im, w_re, w_im, cut);
    modport bfly   (input  valid, a_re, a_im, b_re, b_im, w_re, w_im, cut);
endinterface

interface bfly_out_if;
    logic                               valid; // all butterflies strobe in the same cycle.
    logic signed [fft_pkg::d_width-1:0] c_re;
    logic signed [fft_pkg::d_width-1:0] c_im;
    logic signed [fft_pkg::d_width-1:0] d_re;
    logic signed [fft_pkg::d_width-1:0] d_im;

    modport bfly  (output valid, c_re, c_im, d_re, d_im);
    modport drain (input  valid, c_re, c_im, d_re, d_im);
endinterface

// ==== rtl/butterfly_rad2.sv ====
`timescale 1ns/10ps

module butterfly_rad2 (
    input  logic       clk,
    input  logic       rst_n,
    bfly_in_if.bfly    bin,
    bfly_out_if.bfly   bout
);

    logic signed [fft_pkg::mul_width-1:0]  norm_a_re;
    logic signed [fft_pkg::mul_width-1:0]  norm_a_im;

    logic signed [fft_pkg::mul_width-1:0]  br_wr;
    logic signed [fft_pkg::mul_width-1:0]  bi_wi;
    logic signed [fft_pkg::mul_width-1:0]  bi_wr;
    logic signed [fft_pkg::mul_width-1:0]  br_wi;

    logic signed [fft_pkg::mul_width:0]    mult_re;
    logic signed [fft_pkg::mul_width:0]    mult_im;

    logic signed [fft_pkg::full_width-1:0] c_re_full;
    logic signed [fft_pkg::full_width-1:0] c_im_full;
    logic signed [fft_pkg::full_width-1:0] d_re_full;
    logic signed [fft_pkg::full_width-1:0] d_im_full;

    logic signed [fft_pkg::full_width-1:0] c_re_cut;
    logic signed [fft_pkg::full_width-1:0] c_im_cut;
    logic signed [fft_pkg::full_width-1:0] d_re_cut;
    logic signed [fft_pkg::full_width-1:0] d_im_cut;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // complex product B*W
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign br_wr = bin.b_re * bin.w_re;
    assign bi_wi = bin.b_im * bin.w_im;
    assign bi_wr = bin.b_im * bin.w_re;
    assign br_wi = bin.b_re * bin.w_im;

    assign mult_re = br_wr - bi_wi;
    assign mult_im = bi_wr + br_wi;

    assign norm_a_re = bin.a_re <<< (fft_pkg::w_width - 1); // bring A to the twiddle scale.
    assign norm_a_im = bin.a_im <<< (fft_pkg::w_width - 1);

    assign c_re_full = norm_a_re + mult_re;
    assign c_im_full = norm_a_im + mult_im;
    assign d_re_full = norm_a_re - mult_re;
    assign d_im_full = norm_a_im - mult_im;

    assign c_re_cut = c_re_full >>> bin.cut; // truncates toward minus infinity.
    assign c_im_cut = c_im_full >>> bin.cut;
    assign d_re_cut = d_re_full >>> bin.cut;
    assign d_im_cut = d_im_full >>> bin.cut;

    lim_qnt #(.in_w(fft_pkg::full_width), .out_w(fft_pkg::d_width)) u_lim_c_re (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (bin.valid),
        .din   (c_re_cut),
        .dout  (bout.c_re),
        .valid (bout.valid)
    );
    lim_qnt #(.in_w(fft_pkg::full_width), .out_w(fft_pkg::d_width)) u_lim_c_im (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (bin.valid),
        .din   (c_im_cut),
        .dout  (bout.c_im),
        .valid ()
    );
    lim_qnt #(.in_w(fft_pkg::full_width), .out_w(fft_pkg::d_width)) u_lim_d_re (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (bin.valid),
        .din   (d_re_cut),
        .dout  (bout.d_re),
        .valid ()
    );
    lim_qnt #(.in_w(fft_pkg::full_width), .out_w(fft_pkg::d_width)) u_lim_d_im (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (bin.valid),
        .din   (d_im_cut),
        .dout  (bout.d_im),
        .valid ()
    );

endmodule

// ==== rtl/fft_pkg.sv ====
package fft_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int d_width   = 16; // real or imaginary part of a sample.
    localparam int w_width   = 16; // twiddle part, scale 2^(w_width-1).
    localparam int cut_width = 5;

    localparam int mul_width  = 2 * d_width; // no overflow for two most negative operands.
    localparam int full_width = mul_width + 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int frame_len = 8;
    localparam int n_bfly    = frame_len / 2;

    // twiddles W8^k = exp(-j*2*pi*k/8), scaled by 32767.
    localparam logic signed [w_width-1:0] tw_re [n_bfly] = '{
        16'sd32767,
        16'sd23170,
        16'sd0,
        -16'sd23170
    };

    localparam logic signed [w_width-1:0] tw_im [n_bfly] = '{
        16'sd0,
        -16'sd23170,
        -16'sd32767,
        -16'sd23170
    };

endpackage

// ==== rtl/fft_stage_top.sv ====
`timescale 1ns/10ps

module fft_stage_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic signed [fft_pkg::d_width-1:0]  in_re,
    input  logic signed [fft_pkg::d_width-1:0]  in_im,
    input  logic        [fft_pkg::cut_width-1:0] cut,
    output logic                                out_valid,
    output logic signed [fft_pkg::d_width-1:0]  out_re,
    output logic signed [fft_pkg::d_width-1:0]  out_im
);

    bfly_in_if  bin_if  [fft_pkg::n_bfly] ();
    bfly_out_if bout_if [fft_pkg::n_bfly] ();

    frame_loader u_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_re    (in_re),
        .in_im    (in_im),
        .cut      (cut),
        .bin      (bin_if)
    );

    // one butterfly per pair, all fire in the same cycle.
    for (genvar k = 0; k < fft_pkg::n_bfly; k++) begin : g_bfly
        butterfly_rad2 u_bfly (
            .clk   (clk),
            .rst_n (rst_n),
            .bin   (bin_if[k]),
            .bout  (bout_if[k])
        );
    end

    result_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .bout      (bout_if),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im)
    );

endmodule

// ==== rtl/frame_loader.sv ====
`timescale 1ns/10ps

module frame_loader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic signed [fft_pkg::d_width-1:0]  in_re,
    input  logic signed [fft_pkg::d_width-1:0]  in_im,
    input  logic        [fft_pkg::cut_width-1:0] cut,
    bfly_in_if.loader                           bin [fft_pkg::n_bfly]
);

    localparam int cnt_w = $clog2(fft_pkg::frame_len);

    logic        [cnt_w-1:0]            cnt;
    logic                               last;
    logic signed [fft_pkg::d_width-1:0] smp_re [fft_pkg::frame_len];
    logic signed [fft_pkg::d_width-1:0] smp_im [fft_pkg::frame_len];

    assign last = in_valid && (cnt == cnt_w'(fft_pkg::frame_len - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (in_valid) begin
            cnt <= cnt + cnt_w'(1); // wraps to zero after the eighth sample.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            smp_re[cnt] <= in_re;
            smp_im[cnt] <= in_im;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand sets, pair k with k+4
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 0; k < fft_pkg::n_bfly; k++) begin : g_opnd
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                bin[k].valid <= 1'b0;
            end else begin
                bin[k].valid <= last;
            end
        end

        always_ff @(posedge clk) begin
            if (last) begin
                bin[k].a_re <= smp_re[k];
                bin[k].a_im <= smp_im[k];
                // the eighth sample is taken straight from the input.
                bin[k].b_re <= (k == fft_pkg::n_bfly - 1) ? in_re : smp_re[k+fft_pkg::n_bfly];
                bin[k].b_im <= (k == fft_pkg::n_bfly - 1) ? in_im : smp_im[k+fft_pkg::n_bfly];
                bin[k].w_re <= fft_pkg::tw_re[k];
                bin[k].w_im <= fft_pkg::tw_im[k];
                bin[k].cut  <= cut; // held for the whole frame.
            end
        end
    end

endmodule

// ==== rtl/lim_qnt.sv ====
`timescale 1ns/10ps

module lim_qnt #(
    parameter int in_w  = fft_pkg::full_width,
    parameter int out_w = fft_pkg::d_width
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic signed [in_w-1:0]  din,
    output logic signed [out_w-1:0] dout,
    output logic                    valid
);

    localparam logic signed [in_w-1:0] pos_lim = {{(in_w-out_w+1){1'b0}}, {(out_w-1){1'b1}}};
    localparam logic signed [in_w-1:0] neg_lim = -pos_lim; // symmetric, no most negative code.

    logic signed [out_w-1:0] clamped;

    always_comb begin
        if (din > pos_lim) begin
            clamped = pos_lim[out_w-1:0];
        end else if (din < neg_lim) begin
            clamped = neg_lim[out_w-1:0];
        end else begin
            clamped = din[out_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= en;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            dout <= clamped;
        end
    end

endmodule

// ==== rtl/result_drain.sv ====
`timescale 1ns/10ps

module result_drain (
    input  logic                               clk,
    input  logic                               rst_n,
    bfly_out_if.drain                          bout [fft_pkg::n_bfly],
    output logic                               out_valid,
    output logic signed [fft_pkg::d_width-1:0] out_re,
    output logic signed [fft_pkg::d_width-1:0] out_im
);

    localparam int idx_w = $clog2(fft_pkg::frame_len);

    logic        [fft_pkg::n_bfly-1:0]  res_valid;
    logic signed [fft_pkg::d_width-1:0] res_re  [fft_pkg::frame_len];
    logic signed [fft_pkg::d_width-1:0] res_im  [fft_pkg::frame_len];
    logic signed [fft_pkg::d_width-1:0] hold_re [fft_pkg::frame_len];
    logic signed [fft_pkg::d_width-1:0] hold_im [fft_pkg::frame_len];
    logic        [idx_w-1:0]            rd_idx;
    logic                               busy;
    logic                               cap;

    for (genvar k = 0; k < fft_pkg::n_bfly; k++) begin : g_gather
        assign res_re[k]                   = bout[k].c_re; // C results go out first.
        assign res_im[k]                   = bout[k].c_im;
        assign res_re[k+fft_pkg::n_bfly]   = bout[k].d_re;
        assign res_im[k+fft_pkg::n_bfly]   = bout[k].d_im;
        assign res_valid[k]                = bout[k].valid;
    end

    assign cap = &res_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            rd_idx    <= '0;
            out_valid <= 1'b0;
        end else if (cap) begin
            busy      <= 1'b1; // output 0 leaves on this edge.
            rd_idx    <= idx_w'(1);
            out_valid <= 1'b1;
        end else if (busy) begin
            busy      <= ~&rd_idx;
            rd_idx    <= rd_idx + idx_w'(1);
            out_valid <= 1'b1;
        end else begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cap) begin
            hold_re <= res_re;
            hold_im <= res_im;
            out_re  <= res_re[0];
            out_im  <= res_im[0];
        end else if (busy) begin
            out_re  <= hold_re[rd_idx];
            out_im  <= hold_im[rd_idx];
        end
    end

endmodule

// ==== run.sh ====
#!/bin/bash
# Compiles the testbench with Verilator, runs it and scans the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fft_stage -f build.f -o sim_fft_stage

./obj_dir/sim_fft_stage 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished clean"

// ==== tb/fft_stage_chk.sv ====
`timescale 1ns/10ps

module fft_stage_chk (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               out_valid,
    input logic signed [fft_pkg::d_width-1:0] out_re,
    input logic signed [fft_pkg::d_width-1:0] out_im
);

    localparam int cnt_w = $clog2(fft_pkg::frame_len);
    localparam logic signed [fft_pkg::d_width-1:0] most_neg = {1'b1, {(fft_pkg::d_width-1){1'b0}}};

    logic [cnt_w-1:0] run_cnt; // output beats modulo the frame length.
    int               fails = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cnt <= '0;
        end else if (out_valid) begin
            run_cnt <= run_cnt + cnt_w'(1);
        end
    end

    a_no_min_re: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_re != most_neg)
        else begin
            fails = fails + 1;
            $error("out_re carries the most negative code");
        end

    a_no_min_im: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_im != most_neg)
        else begin
            fails = fails + 1;
            $error("out_im carries the most negative code");
        end

    // runs hold whole frames of 8 beats.
    a_run_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_valid) |-> run_cnt == '0)
        else begin
            fails = fails + 1;
            $error("out_valid run is not a whole number of frames");
        end

endmodule

bind fft_stage_top fft_stage_chk chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_re    (out_re),
    .out_im    (out_im)
);

// ==== tb/fft_stage_monitor.sv ====
`timescale 1ns/10ps

module fft_stage_monitor (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic signed [fft_pkg::d_width-1:0]   in_re,
    input  logic signed [fft_pkg::d_width-1:0]   in_im,
    input  logic        [fft_pkg::cut_width-1:0] cut,
    input  logic                                 out_valid,
    input  logic signed [fft_pkg::d_width-1:0]   out_re,
    input  logic signed [fft_pkg::d_width-1:0]   out_im,
    output int                                   val_errs,
    output int                                   oth_errs,
    output int                                   pending,
    output int                                   beats
);

    longint                             smp_re [fft_pkg::frame_len];
    longint                             smp_im [fft_pkg::frame_len];
    int                                 cnt;
    int                                 cyc;
    logic signed [fft_pkg::d_width-1:0] exp_re [$];
    logic signed [fft_pkg::d_width-1:0] exp_im [$];
    int                                 exp_cyc [$];

    initial begin
        val_errs = 0;
        oth_errs = 0;
        pending  = 0;
        beats    = 0;
        cnt      = 0;
        cyc      = 0;
    end

    function automatic longint clamp(input longint v);
        longint lim;
        lim = (longint'(1) <<< (fft_pkg::d_width - 1)) - 1;
        if (v > lim) return lim;
        if (v < -lim) return -lim;
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference butterflies
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic push_frame(input longint c);
        longint mr;
        longint mi;
        longint ar;
        longint ai;
        longint res_re [fft_pkg::frame_len];
        longint res_im [fft_pkg::frame_len];
        for (int k = 0; k < fft_pkg::n_bfly; k++) begin
            mr = smp_re[k+4] * fft_pkg::tw_re[k] - smp_im[k+4] * fft_pkg::tw_im[k];
            mi = smp_im[k+4] * fft_pkg::tw_re[k] + smp_re[k+4] * fft_pkg::tw_im[k];
            ar = smp_re[k] * (longint'(2) ** (fft_pkg::w_width - 1));
            ai = smp_im[k] * (longint'(2) ** (fft_pkg::w_width - 1));
            res_re[k]   = clamp((ar + mr) >>> c); // arithmetic shift rounds toward minus infinity.
            res_im[k]   = clamp((ai + mi) >>> c);
            res_re[k+4] = clamp((ar - mr) >>> c);
            res_im[k+4] = clamp((ai - mi) >>> c);
        end
        for (int j = 0; j < fft_pkg::frame_len; j++) begin
            exp_re.push_back(res_re[j][fft_pkg::d_width-1:0]);
            exp_im.push_back(res_im[j][fft_pkg::d_width-1:0]);
            exp_cyc.push_back(cyc + 3 + j); // seen just before the third edge after the last sample.
        end
    endtask

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!rst_n) begin
            cnt = 0; // a partial frame is dropped.
            exp_re.delete();
            exp_im.delete();
            exp_cyc.delete();
            if (out_valid) begin
                oth_errs = oth_errs + 1;
                $display("error: out_valid is high during reset at cycle %0d", cyc);
            end
        end else begin
            if (out_valid) begin
                if (exp_re.size() == 0) begin
                    oth_errs = oth_errs + 1;
                    $display("error: output beat at cycle %0d with no frame pending", cyc);
                end else begin
                    if (exp_cyc[0] != cyc) begin
                        oth_errs = oth_errs + 1;
                        $display("error: output beat at cycle %0d, expected at cycle %0d",
                                 cyc, exp_cyc[0]);
                    end
                    if (out_re !== exp_re[0]) begin
                        val_errs = val_errs + 1;
                        $display("[FAIL] out_re: expected 0x%h, got 0x%h", exp_re[0], out_re);
                    end
                    if (out_im !== exp_im[0]) begin
                        val_errs = val_errs + 1;
                        $display("[FAIL] out_im: expected 0x%h, got 0x%h", exp_im[0], out_im);
                    end
                    beats = beats + 1;
                    void'(exp_re.pop_front());
                    void'(exp_im.pop_front());
                    void'(exp_cyc.pop_front());
                end
            end else if (exp_cyc.size() > 0 && exp_cyc[0] <= cyc) begin
                oth_errs = oth_errs + 1;
                $display("error: output beat missing at cycle %0d", cyc);
                void'(exp_re.pop_front());
                void'(exp_im.pop_front());
                void'(exp_cyc.pop_front());
            end
            if (in_valid) begin
                smp_re[cnt] = in_re;
                smp_im[cnt] = in_im;
                if (cnt == fft_pkg::frame_len - 1) begin
                    push_frame(cut); // cut counts only with the eighth sample.
                    cnt = 0;
                end else begin
                    cnt = cnt + 1;
                end
            end
        end
        pending = exp_re.size();
    end

endmodule

// ==== tb/tb_fft_stage.sv ====
`timescale 1ns/10ps

module tb_fft_stage;

    localparam int clk_period = 8;
    localparam int n_full     = 16;         // complete frames over all tests.
    localparam int n_frames   = n_full + 1; // and the one cut short by reset.
    localparam int wd_cycles  = (n_frames * fft_pkg::frame_len + 20) * 2;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 in_valid;
    logic signed [fft_pkg::d_width-1:0]   in_re;
    logic signed [fft_pkg::d_width-1:0]   in_im;
    logic        [fft_pkg::cut_width-1:0] cut;
    logic                                 out_valid;
    logic signed [fft_pkg::d_width-1:0]   out_re;
    logic signed [fft_pkg::d_width-1:0]   out_im;
    int                                   val_errs;
    int                                   oth_errs;
    int                                   pending;
    int                                   beats;
    int                                   tb_errs;
    int                                   chk_errs;

    fft_stage_top dut0 (.*);

    fft_stage_monitor mon0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(wd_cycles * clk_period);
        $display("timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("tests failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [fft_pkg::d_width-1:0] rand_word(input bit big);
        logic [31:0] r;
        r = $urandom;
        if (big) return {r[15], ~r[15], r[13:0]}; // magnitude of at least half scale.
        return r[fft_pkg::d_width-1:0];
    endfunction

    task automatic send_frame(input int frame_cut, input int n_smp, input bit big,
                              input int gap_max, input bit jitter);
        int gap;
        int r;
        for (int i = 0; i < n_smp; i++) begin
            gap = $urandom_range(gap_max, 0);
            repeat (gap) begin
                @(posedge clk);
                r = $urandom;
                in_valid <= 1'b0;
                if (jitter) begin
                    cut <= r[fft_pkg::cut_width-1:0];
                end
            end
            @(posedge clk);
            r = $urandom;
            in_valid <= 1'b1;
            in_re    <= rand_word(big);
            in_im    <= rand_word(big);
            if (jitter && i < fft_pkg::frame_len - 1) begin
                cut <= r[fft_pkg::cut_width-1:0]; // only the eighth sample's cut counts.
            end else begin
                cut <= frame_cut[fft_pkg::cut_width-1:0];
            end
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        in_valid <= 1'b0;
        wait (pending == 0);
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(99));
        tb_errs  = 0;
        chk_errs = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_re    = '0;
        in_im    = '0;
        cut      = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        repeat (6) send_frame(fft_pkg::w_width - 1, 8, 1'b0, 0, 1'b0); // unity gain, no gaps.
        wait_drained();
        repeat (4) send_frame(2 * $urandom_range(1, 0), 8, 1'b1, 0, 1'b0); // saturation.
        wait_drained();
        repeat (4) send_frame($urandom_range(20, 10), 8, 1'b0, 2, 1'b1);
        wait_drained();

        send_frame(fft_pkg::w_width - 1, $urandom_range(6, 2), 1'b0, 1, 1'b0);
        @(posedge clk);
        in_valid <= 1'b0;
        rst_n    <= 1'b0; // drops the partial frame.
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) send_frame(fft_pkg::w_width - 1, 8, 1'b0, 1, 1'b0);
        wait_drained();

        if (beats != n_full * fft_pkg::frame_len) begin
            tb_errs = tb_errs + 1;
            $display("error: %0d output beats checked instead of %0d",
                     beats, n_full * fft_pkg::frame_len);
        end
        chk_errs = dut0.chk0.fails;
        $display("error count: %0d value, %0d assertion, %0d other",
                 val_errs, chk_errs, oth_errs + tb_errs);
        if (val_errs + chk_errs + oth_errs + tb_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
